// ==== rtl/muladd_cfg.svh ====
`ifndef MULADD_CFG_SVH
`define MULADD_CFG_SVH

// operand and result width
`define MULADD_DATA_W 32

// full signed product, also the accumulator width
`define MULADD_PROD_W (2*`MULADD_DATA_W)

// iteration counter, up to 1023 periods per run
`define MULADD_ITER_W 10

// period length and start delay share this width
`define MULADD_PERIOD_W 5

// right shift applied to the sum before truncation
`define MULADD_SHIFT_W 6

`endif

// ==== rtl/muladd_pkg.sv ====
`default_nettype none

`include "muladd_cfg.svh"

package muladd_pkg;

   // operation selected by the configuration word
   typedef enum logic {
      MULADD_MACC = 1'b0, // sum of products
      MULADD_MSUB = 1'b1  // negated sum of products
   } muladd_op_e;

   // configuration word, held stable from run until done
   typedef struct packed {
      muladd_op_e                  op;
      logic [`MULADD_ITER_W-1:0]   iterations; // number of periods
      logic [`MULADD_PERIOD_W-1:0] period;     // samples per sum
      logic [`MULADD_PERIOD_W-1:0] delay;      // cycles between run and sample 0
      logic [`MULADD_SHIFT_W-1:0]  shift;      // arithmetic right shift of the result
   } muladd_cfg_t;

   // per-sample control from the sequencer
   typedef struct packed {
      logic en;    // operand pair counts this cycle
      logic first; // operand pair opens a new sum
   } muladd_ctrl_t;

endpackage

`default_nettype wire

// ==== rtl/muladd_seq.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "muladd_cfg.svh"

module muladd_seq (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run,
   input  muladd_pkg::muladd_cfg_t  cfg,
   output muladd_pkg::muladd_ctrl_t ctrl,
   output logic                     done
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_DELAY,
      S_ACTIVE
   } state_e;

   state_e                      state;
   logic [`MULADD_PERIOD_W-1:0] delay_cnt; // remaining delay cycles minus one
   logic [`MULADD_PERIOD_W-1:0] idx;       // position inside the current period
   logic [`MULADD_ITER_W-1:0]   iter_cnt;  // completed periods
   logic                        no_work;
   logic                        last_idx;
   logic                        last_iter;

   // a zero count in either dimension means no samples at all
   assign no_work   = (cfg.iterations == '0) || (cfg.period == '0);
   assign last_idx  = (idx == cfg.period - 1'b1);
   assign last_iter = (iter_cnt == cfg.iterations - 1'b1);

   assign ctrl.en    = (state == S_ACTIVE);
   assign ctrl.first = (state == S_ACTIVE) && (idx == '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= S_IDLE;
         delay_cnt <= '0;
         idx       <= '0;
         iter_cnt  <= '0;
         done      <= 1'b0;
      end else begin
         done <= 1'b0; // single cycle pulse
         if (run) begin
            // run also restarts a busy unit
            idx       <= '0;
            iter_cnt  <= '0;
            delay_cnt <= cfg.delay - 1'b1;
            if (cfg.delay != '0) begin
               state <= S_DELAY;
            end else if (no_work) begin
               state <= S_IDLE;
               done  <= 1'b1;
            end else begin
               state <= S_ACTIVE;
            end
         end else begin
            case (state)
               S_DELAY: begin
                  if (delay_cnt == '0) begin
                     if (no_work) begin
                        state <= S_IDLE;
                        done  <= 1'b1; // empty run ends where sample 0 would be
                     end else begin
                        state <= S_ACTIVE;
                     end
                  end else begin
                     delay_cnt <= delay_cnt - 1'b1;
                  end
               end
               S_ACTIVE: begin
                  if (last_idx) begin
                     idx <= '0;
                     if (last_iter) begin
                        state <= S_IDLE;
                        done  <= 1'b1;
                     end else begin
                        iter_cnt <= iter_cnt + 1'b1;
                     end
                  end else begin
                     idx <= idx + 1'b1;
                  end
               end
               default: state <= S_IDLE;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/muladd_mult_pipe.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "muladd_cfg.svh"

// two register stages, maps onto a DSP block with input and output registers
module muladd_mult_pipe (
   input  logic                             clk,
   input  logic signed [`MULADD_DATA_W-1:0] in1,
   input  logic signed [`MULADD_DATA_W-1:0] in2,
   output logic signed [`MULADD_PROD_W-1:0] product
);

   logic signed [`MULADD_DATA_W-1:0] in1_q; // operand stage
   logic signed [`MULADD_DATA_W-1:0] in2_q;

   // operands of cycle S appear on product at S+2
   always_ff @(posedge clk) begin
      in1_q   <= in1;
      in2_q   <= in2;
      product <= in1_q * in2_q; // full width signed product
   end

endmodule

`default_nettype wire

// ==== rtl/muladd_accum.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "muladd_cfg.svh"

module muladd_accum (
   input  logic                             clk,
   input  logic                             rst,
   input  muladd_pkg::muladd_cfg_t          cfg,
   input  muladd_pkg::muladd_ctrl_t         ctrl,
   input  logic signed [`MULADD_PROD_W-1:0] product,
   output logic        [`MULADD_DATA_W-1:0] out,
   output logic                             sum_last
);

   muladd_pkg::muladd_ctrl_t         ctrl_d1; // lines up with the operand registers
   muladd_pkg::muladd_ctrl_t         ctrl_d2; // lines up with the product register
   logic signed [`MULADD_PROD_W-1:0] term;
   logic signed [`MULADD_PROD_W-1:0] base;
   logic signed [`MULADD_PROD_W-1:0] sum;
   logic signed [`MULADD_PROD_W-1:0] shifted;
   logic                             period_end;

   // control pipeline and the end-of-sum flag
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ctrl_d1  <= '0;
         ctrl_d2  <= '0;
         sum_last <= 1'b0;
      end else begin
         ctrl_d1  <= ctrl;
         ctrl_d2  <= ctrl_d1;
         sum_last <= ctrl_d2.en && period_end;
      end
   end

   // sample in stage 2 closes its sum when the one behind it
   // opens a new period or is not a sample at all
   assign period_end = ctrl_d1.first || !ctrl_d1.en;

   assign term = (cfg.op == muladd_pkg::MULADD_MSUB) ? -product : product;
   assign base = ctrl_d2.first ? '0 : sum; // reload at period start

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sum <= '0;
      end else if (ctrl_d2.en) begin
         sum <= base + term;
      end
   end

   // sum is signed so this shift keeps the sign
   assign shifted = sum >>> cfg.shift;
   assign out     = shifted[`MULADD_DATA_W-1:0];

endmodule

`default_nettype wire

// ==== rtl/muladd_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "muladd_cfg.svh"

module muladd_unit (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             run,
   input  muladd_pkg::muladd_cfg_t          cfg,
   input  logic signed [`MULADD_DATA_W-1:0] in1,
   input  logic signed [`MULADD_DATA_W-1:0] in2,
   output logic        [`MULADD_DATA_W-1:0] out,
   output logic                             sum_last,
   output logic                             done
);

   muladd_pkg::muladd_ctrl_t         ctrl;    // per-sample flags, operand cycle
   logic signed [`MULADD_PROD_W-1:0] product; // two cycles behind the operands

   // delay, period and iteration counting
   muladd_seq seq_i (
      .clk  (clk),
      .rst  (rst),
      .run  (run),
      .cfg  (cfg),
      .ctrl (ctrl),
      .done (done)
   );

   muladd_mult_pipe mult_i (
      .clk     (clk),
      .in1     (in1),
      .in2     (in2),
      .product (product)
   );

   // realigns ctrl with product, result three cycles after the operands
   muladd_accum accum_i (
      .clk      (clk),
      .rst      (rst),
      .cfg      (cfg),
      .ctrl     (ctrl),
      .product  (product),
      .out      (out),
      .sum_last (sum_last)
   );

endmodule

`default_nettype wire

// ==== test/muladd_unit_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

// bound once into muladd_seq and once into muladd_accum
// each instance checks only the flags its host module drives
module muladd_unit_checker #(
   parameter bit CHECK_DONE     = 1'b1, // host drives done
   parameter bit CHECK_SUM_LAST = 1'b1  // host drives sum_last
) (
   input logic                     clk,
   input logic                     rst,
   input muladd_pkg::muladd_ctrl_t ctrl,
   input logic                     done,
   input logic                     sum_last
);

   int fail_count = 0; // failed assertions of this instance

   if (CHECK_DONE) begin : g_done
      // done lasts exactly one cycle
      done_single_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
         else begin
            fail_count++;
            $error("done stayed high for a second cycle");
         end
   end

   // a sample can only open a sum if it counts
   first_needs_en: assert property (@(posedge clk) disable iff (rst) ctrl.first |-> ctrl.en)
      else begin
         fail_count++;
         $error("ctrl.first high while ctrl.en is low");
      end

   if (CHECK_SUM_LAST) begin : g_sum_last
      sum_last_after_reset: assert property (@(posedge clk) $fell(rst) |-> !sum_last)
         else begin
            fail_count++;
            $error("sum_last high in the first cycle after reset");
         end
   end

endmodule

`default_nettype wire

// ==== test/muladd_unit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "muladd_cfg.svh"

module muladd_unit_tb;

   localparam int CLK_PERIOD  = 20;
   localparam int RST_CYCLES  = 8;
   localparam int DRIVE_DELAY = 2;
   localparam int TRACE_DEPTH = 256;
   localparam int TAIL_CYCLES = 3; // quiet cycles checked after the last result
   localparam logic [`MULADD_DATA_W-1:0] IDLE_DATA = {(`MULADD_DATA_W/8){8'h5a}};

   logic                             clk;
   logic                             rst;
   logic                             run;
   muladd_pkg::muladd_cfg_t          cfg;
   logic signed [`MULADD_DATA_W-1:0] in1;
   logic signed [`MULADD_DATA_W-1:0] in2;
   logic        [`MULADD_DATA_W-1:0] out;
   logic                             sum_last;
   logic                             done;

   logic [`MULADD_DATA_W-1:0] trace_mem [0:TRACE_DEPTH-1];
   int value_errors;
   int flag_errors;
   int assert_errors;
   int watchdog_cycles = 0;

   muladd_unit muladd_unit_i (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .cfg      (cfg),
      .in1      (in1),
      .in2      (in2),
      .out      (out),
      .sum_last (sum_last),
      .done     (done)
   );

   bind muladd_seq muladd_unit_checker #(.CHECK_SUM_LAST(1'b0)) seq_chk_i (
      .clk(clk), .rst(rst), .ctrl(ctrl), .done(done), .sum_last(1'b0));
   bind muladd_accum muladd_unit_checker #(.CHECK_DONE(1'b0)) accum_chk_i (
      .clk(clk), .rst(rst), .ctrl(ctrl_d2), .done(1'b0), .sum_last(sum_last));

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   initial begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("timeout: the tests did not finish within %0d clock cycles", watchdog_cycles);
      $display("TESTBENCH FAILED");
      $finish;
   end

   function automatic int samples_of(input int base);
      return int'(trace_mem[base+2][`MULADD_ITER_W-1:0]) *
             int'(trace_mem[base+3][`MULADD_PERIOD_W-1:0]);
   endfunction

   // config line, operand pairs, then one result per period (or one held value)
   function automatic int record_words(input int base);
      int n_samples;
      n_samples = samples_of(base);
      if (n_samples == 0) return 6 + 1;
      return 6 + 2 * n_samples + int'(trace_mem[base+2][`MULADD_ITER_W-1:0]);
   endfunction

   function automatic int cycle_budget();
      int base;
      int total;
      base  = 0;
      total = RST_CYCLES;
      while (base < TRACE_DEPTH && trace_mem[base] != '0) begin
         total += int'(trace_mem[base+4][`MULADD_PERIOD_W-1:0]) + samples_of(base) + 10;
         base  += record_words(base);
      end
      return total;
   endfunction

   task automatic check_out(input string name, input logic [`MULADD_DATA_W-1:0] expected,
                            input logic [`MULADD_DATA_W-1:0] actual);
      if (actual !== expected) begin
         value_errors++;
         $display("FAIL %s out at %0t: expected %h, actual %h", name, $time, expected, actual);
      end
   endtask

   task automatic check_flag(input string name, input string what, input logic expected,
                             input logic actual);
      if (actual !== expected) begin
         flag_errors++;
         $display("FAIL %s %s at %0t: expected %b, actual %b", name, what, $time,
                  expected, actual);
      end
   endtask

   task automatic run_test(input int base);
      string                   name;
      muladd_pkg::muladd_cfg_t tcfg;
      int n_iter, n_per, n_delay, n_samples;
      int pairs, results, hold_idx, hold_from, end_c;
      int c, due_k, drive_k;
      logic exp_last;
      logic exp_done;
      name            = $sformatf("test%0d", trace_mem[base]);
      tcfg.op         = muladd_pkg::muladd_op_e'(trace_mem[base+1][0]);
      tcfg.iterations = trace_mem[base+2][`MULADD_ITER_W-1:0];
      tcfg.period     = trace_mem[base+3][`MULADD_PERIOD_W-1:0];
      tcfg.delay      = trace_mem[base+4][`MULADD_PERIOD_W-1:0];
      tcfg.shift      = trace_mem[base+5][`MULADD_SHIFT_W-1:0];
      n_iter    = int'(tcfg.iterations);
      n_per     = int'(tcfg.period);
      n_delay   = int'(tcfg.delay);
      n_samples = n_iter * n_per;
      pairs     = base + 6;
      results   = pairs + 2 * n_samples;
      hold_idx  = (n_samples == 0) ? 0 : n_iter - 1;
      hold_from = (n_samples == 0) ? 1 : n_delay + n_samples + 4; // out must stay put from here
      end_c     = n_delay + n_samples + 3 + TAIL_CYCLES;
      run = 1'b1; // cycle 0
      cfg = tcfg;
      in1 = IDLE_DATA;
      in2 = IDLE_DATA;
      for (c = 1; c <= end_c; c++) begin
         @(posedge clk);
         #DRIVE_DELAY;
         // outputs here belong to the edge just passed
         due_k    = c - n_delay - 4;
         exp_last = (n_samples > 0) && (due_k >= 0) && (due_k < n_samples) &&
                    (due_k % n_per == n_per - 1);
         exp_done = (c == n_delay + n_samples + 1);
         check_flag(name, "sum_last", exp_last, sum_last);
         check_flag(name, "done", exp_done, done);
         if (exp_last) begin
            check_out(name, trace_mem[results + due_k / n_per], out);
         end else if (c >= hold_from) begin
            check_out(name, trace_mem[results + hold_idx], out);
         end
         run     = 1'b0;
         drive_k = c - n_delay - 1; // sample whose operands go out now
         if (drive_k >= 0 && drive_k < n_samples) begin
            in1 = trace_mem[pairs + 2 * drive_k];
            in2 = trace_mem[pairs + 2 * drive_k + 1];
         end else begin
            in1 = IDLE_DATA; // ignored, no sample
            in2 = IDLE_DATA;
         end
      end
   endtask

   initial begin
      int base;
      int test_cnt;
      rst           = 1'b1;
      run           = 1'b0;
      cfg           = '0;
      in1           = '0;
      in2           = '0;
      value_errors  = 0;
      flag_errors   = 0;
      assert_errors = 0;
      $readmemh("test/muladd_trace.txt", trace_mem);
      watchdog_cycles = cycle_budget();
      repeat (RST_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst      = 1'b0;
      base     = 0;
      test_cnt = 0;
      while (base < TRACE_DEPTH && trace_mem[base] != '0) begin
         run_test(base);
         base += record_words(base);
         test_cnt++;
      end
      if (test_cnt == 0) begin
         flag_errors++;
         $display("no tests found in the trace file");
      end
      assert_errors = muladd_unit_i.seq_i.seq_chk_i.fail_count +
                      muladd_unit_i.accum_i.accum_chk_i.fail_count;
      $display("%0d tests, errors: %0d value, %0d flag, %0d assertion", test_cnt,
               value_errors, flag_errors, assert_errors);
      if (value_errors + flag_errors + assert_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/muladd_trace.txt ====
// config line: id op iterations period delay shift, all hex, op 0 is MACC and 1 is MSUB
// then iterations*period lines "in1 in2", then one expected out per period (id 0 ends)
// a run without samples lists the one out value that must hold during it
1 0 3 2 0 0     // macc, three periods of two, no delay
00000003 00000004
00000005 00000006
00000007 00000008
00000002 0000000a
00000064 000000c8
00000001 00000001
0000002a
0000004c
00004e21
2 1 2 3 2 0     // msub with negative operands, delay 2
fffffffd 00000004
00000005 fffffff9
fffffffe fffffff7
0000000a 0000000a
ffffffff 00000032
00000006 00000001
0000001d
ffffffc8
3 0 2 2 1 4     // shift 4, sum wider than 32 bits
00010000 00010000
00010000 00000030
fffff000 00000100
00000007 00000001
10030000
ffff0000
4 0 0 2 3 4     // no iterations, out holds the last sum
ffff0000
5 0 3 1 5 1     // period of one, delay 5, shift 1
00000009 00000009
fffffffb 00000003
7fffffff 00000002
00000028
fffffff8
7fffffff
6 1 0 3 0 1     // no iterations, no delay
7fffffff
0

// ==== flist.f ====
+incdir+rtl
rtl/muladd_pkg.sv
rtl/muladd_seq.sv
rtl/muladd_mult_pipe.sv
rtl/muladd_accum.sv
rtl/muladd_unit.sv
test/muladd_unit_checker.sv
test/muladd_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f flist.f \
   --top-module muladd_unit_tb \
   -Mdir obj_dir \
   -o muladd_sim

# keep running after an assertion error so the testbench gives its verdict
./obj_dir/muladd_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi
